// File: compile.f
hw/fetch_pkg.sv
hw/instr_fetch.sv
hw/sys_instr_decoder.sv
hw/fetch_cfg_regs.sv
hw/fetch_probe_top.sv
verification/fetch_probe_assertions.sv
verification/fetch_probe_tb.sv

// File: Makefile
# Verilator build and run of the fetch probe testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       := fetch_probe_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
RUN_ARGS  := +verilator+error+limit+100
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(RUN_ARGS) 2>&1 | tee $(SIM_LOG)
	@grep -q '^>>> PASS$$' $(SIM_LOG) || (echo "simulation failed, see $(SIM_LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// File: verification/fetch_probe_tb.sv
// ******************************
// Fetch probe testbench: memory model,
// reference classifier and directed tests
// ******************************

`timescale 1ns/10ps
`default_nettype none

module fetch_probe_tb;

  import fetch_pkg::*;

  // Six short tests of a few hundred cycles each
  localparam int MAX_CYCLES = 20000;

  logic        clk_i;
  logic        rst_n_i;
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  instr_t      instr_rdata_i;
  logic        instr_err_i;
  logic        irq_i;
  logic        reg_we_i;
  reg_addr_t   reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic [31:0] reg_rdata_o;
  logic        instr_valid_o;
  class_t      instr_class_o;
  addr_t       instr_pc_o;
  logic        core_sleep_o;

  instr_t      prog_mem [addr_t];
  bit          err_mem [addr_t];
  count_t      seen_count [NUM_CLASSES];
  class_t      seen_class [$];
  addr_t       seen_pc [$];
  logic        seen_sleep [$];
  addr_t       granted_addr [$];
  logic        last_sleep;
  logic [31:0] lcg_state = 32'hc55e98e7;

  fetch_probe_top i_dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Unwritten locations hold an ADDI whose immediate folds in every address bit
  function automatic instr_t mem_word(addr_t a);
    if (prog_mem.exists(a)) begin
      return prog_mem[a];
    end
    return {a[31:20] ^ a[19:8] ^ a[11:0], 13'd0, 7'b0010011};
  endfunction

  function automatic instr_t sys_word(logic [11:0] f12);
    return {f12, 13'd0, OPC_SYSTEM};
  endfunction

  function automatic instr_t jal_word(int offset);
    logic [20:0] imm;
    imm = offset[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
  endfunction

  function automatic class_t ref_class(instr_t w, logic err);
    if (err) return CLASS_FETCH_ERR;
    if (w[1:0] != 2'b11 || w == 32'h0 || w == 32'hffff_ffff) return CLASS_ILLEGAL;
    if (w[6:0] != OPC_SYSTEM || w[19:7] != 13'd0) return CLASS_OTHER;
    if (w[31:20] == F12_ECALL) return CLASS_ECALL;
    if (w[31:20] == F12_EBREAK) return CLASS_EBREAK;
    if (w[31:20] == F12_MRET) return CLASS_MRET;
    if (w[31:20] == F12_DRET) return CLASS_DRET;
    if (w[31:20] == F12_WFI) return CLASS_WFI;
    return CLASS_ILLEGAL;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_class(string name, class_t exp, class_t act);
    if (act !== exp) abort_run($sformatf("mismatch %s: expected class %0d, actual %0d",
                                         name, exp, act));
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (act !== exp) abort_run($sformatf("mismatch %s: expected 0x%08h, actual 0x%08h",
                                         name, exp, act));
  endtask

  task automatic check_count(string name, count_t exp, count_t act);
    if (act !== exp) abort_run($sformatf("mismatch %s: expected %0d, actual %0d",
                                         name, exp, act));
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) abort_run($sformatf("mismatch %s: expected %b, actual %b",
                                         name, exp, act));
  endtask

  task automatic reg_write(reg_addr_t addr, logic [31:0] data);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    step();
    reg_we_i    = 1'b0;
  endtask

  // Combinational read data is sampled mid-cycle
  task automatic reg_read(reg_addr_t addr, output logic [31:0] data);
    reg_addr_i = addr;
    @(negedge clk_i);
    data = reg_rdata_o;
    step();
  endtask

  task automatic start_fetch(addr_t boot);
    reg_write(REG_BOOT, boot);
    reg_write(REG_CTRL, 32'd1);
  endtask

  task automatic expect_report(string name, class_t exp_class, addr_t exp_pc);
    int waited;
    waited = 0;
    while (seen_class.size() == 0) begin
      if (waited == 100) abort_run($sformatf("%s: no instruction reported in 100 cycles", name));
      step();
      waited++;
    end
    last_sleep = seen_sleep.pop_front();
    check_class(name, exp_class, seen_class.pop_front());
    check_addr(name, exp_pc, seen_pc.pop_front());
    check_addr($sformatf("%s fetch address", name), exp_pc, granted_addr.pop_front());
    seen_count[exp_class] = seen_count[exp_class] + count_t'(1);
  endtask

  // Clear the enable and wait until the port has gone quiet
  task automatic stop_fetch(string name);
    int     quiet;
    int     waited;
    addr_t  pc;
    class_t exp_class;
    reg_write(REG_CTRL, 32'd0);
    quiet  = 0;
    waited = 0;
    while (quiet < 10) begin
      if (waited == 200) abort_run($sformatf("%s: requests did not stop after disable", name));
      step();
      waited++;
      quiet = (instr_req_o || instr_valid_o) ? 0 : quiet + 1;
    end
    // Reports of fetches still in flight when the enable fell
    while (seen_class.size() != 0) begin
      pc        = granted_addr.pop_front();
      exp_class = ref_class(mem_word(pc), err_mem.exists(pc) != 0);
      check_addr($sformatf("%s drain", name), pc, seen_pc.pop_front());
      check_class($sformatf("%s drain", name), exp_class, seen_class.pop_front());
      seen_count[exp_class] = seen_count[exp_class] + count_t'(1);
    end
    seen_sleep.delete();
    granted_addr.delete();
  endtask

  task automatic test_reset();
    logic [31:0] rd;
    check_flag("reset req", 1'b0, instr_req_o);
    check_flag("reset valid", 1'b0, instr_valid_o);
    check_flag("reset sleep", 1'b0, core_sleep_o);
    reg_read(REG_BOOT, rd);
    check_addr("reset boot", BOOT_RESET, rd);
    for (int k = 0; k < NUM_CLASSES; k++) begin
      reg_read(REG_COUNT_BASE + reg_addr_t'(k), rd);
      check_count($sformatf("reset counter %0d", k), '0, rd[15:0]);
    end
  endtask

  task automatic test_straight();
    instr_t words [8];
    words = '{sys_word(F12_ECALL), sys_word(F12_EBREAK), sys_word(F12_MRET),
              sys_word(F12_DRET), sys_word(12'h123), 32'h0000_4501, 32'hffff_ffff,
              32'h0050_0093};
    for (int i = 0; i < 8; i++) prog_mem[32'h1000 + addr_t'(4 * i)] = words[i];
    start_fetch(32'h0000_1000);
    for (int i = 0; i < 8; i++) begin
      expect_report("straight", ref_class(words[i], 1'b0), 32'h1000 + addr_t'(4 * i));
    end
    stop_fetch("straight");
  endtask

  task automatic test_jal();
    addr_t pcs [5];
    pcs[0] = 32'h2000;
    pcs[1] = 32'h2004;
    pcs[2] = pcs[1] + addr_t'(256);
    pcs[3] = pcs[2] + 32'd4;
    pcs[4] = pcs[3] - 32'd64;
    prog_mem[pcs[0]] = 32'h0010_0093;
    prog_mem[pcs[1]] = jal_word(256);
    prog_mem[pcs[2]] = 32'h0020_0093;
    prog_mem[pcs[3]] = jal_word(-64);
    start_fetch(pcs[0]);
    for (int i = 0; i < 5; i++) expect_report("jal", ref_class(mem_word(pcs[i]), 1'b0), pcs[i]);
    stop_fetch("jal");
  endtask

  task automatic test_wfi();
    prog_mem[32'h3000] = sys_word(F12_WFI);
    prog_mem[32'h3004] = 32'h0010_0113;
    start_fetch(32'h0000_3000);
    expect_report("wfi", CLASS_WFI, 32'h3000);
    check_flag("wfi sleep with report", 1'b1, last_sleep);
    repeat (20) begin
      step();
      check_flag("wfi sleeping", 1'b1, core_sleep_o);
      check_flag("wfi no request", 1'b0, instr_req_o);
    end
    irq_i = 1'b1;
    step();
    irq_i = 1'b0;
    check_flag("wfi wake", 1'b0, core_sleep_o);
    expect_report("wfi resume", ref_class(prog_mem[32'h3004], 1'b0), 32'h3004);
    stop_fetch("wfi");
  endtask

  // A JAL that faults must neither jump nor keep its own class
  task automatic test_fetch_err();
    addr_t a;
    prog_mem[32'h4000] = 32'h0030_0193;
    prog_mem[32'h4004] = jal_word(64);
    prog_mem[32'h4008] = 32'h0040_0213;
    err_mem[32'h4004]  = 1'b1;
    start_fetch(32'h0000_4000);
    for (int i = 0; i < 3; i++) begin
      a = 32'h4000 + addr_t'(4 * i);
      expect_report("fetch error", ref_class(prog_mem[a], err_mem.exists(a) != 0), a);
    end
    stop_fetch("fetch error");
  endtask

  task automatic test_counters();
    logic [31:0] rd;
    reg_read(REG_CTRL, rd);
    check_flag("enable cleared", 1'b0, rd[0]);
    for (int k = 0; k < NUM_CLASSES; k++) begin
      reg_read(REG_COUNT_BASE + reg_addr_t'(k), rd);
      check_count($sformatf("counter %0d", k), seen_count[k], rd[15:0]);
    end
    reg_write(REG_COUNT_BASE + reg_addr_t'(CLASS_ECALL), '0);
    seen_count[CLASS_ECALL] = '0;
    reg_read(REG_COUNT_BASE + reg_addr_t'(CLASS_ECALL), rd);
    check_count("ecall counter cleared", seen_count[CLASS_ECALL], rd[15:0]);
    reg_read(REG_COUNT_BASE + reg_addr_t'(CLASS_EBREAK), rd);
    check_count("ebreak counter kept", seen_count[CLASS_EBREAK], rd[15:0]);
  endtask

  // Memory model serving one fetch at a time with random grant and rvalid gaps
  task automatic serve_fetch();
    addr_t a;
    int    gap;
    gap = int'(lcg_next() >> 30);
    repeat (gap) step();
    a = instr_addr_o;
    granted_addr.push_back(a);
    instr_gnt_i = 1'b1;
    step();
    instr_gnt_i = 1'b0;
    gap = int'(lcg_next() >> 30);
    repeat (gap) step();
    instr_rvalid_i = 1'b1;
    instr_rdata_i  = mem_word(a);
    instr_err_i    = err_mem.exists(a) != 0;
    step();
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
  endtask

  initial begin : mem_model
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    step();
    forever begin
      if (rst_n_i && (instr_req_o === 1'b1)) serve_fetch();
      else step();
    end
  end

  always @(negedge clk_i) begin
    if (rst_n_i && instr_valid_o) begin
      seen_class.push_back(instr_class_o);
      seen_pc.push_back(instr_pc_o);
      seen_sleep.push_back(core_sleep_o);
    end
  end

  initial begin : watchdog
    repeat (MAX_CYCLES) @(posedge clk_i);
    abort_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
  end

  initial begin : main
    rst_n_i     = 1'b0;
    irq_i       = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    foreach (seen_count[k]) seen_count[k] = '0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    test_reset();
    test_straight();
    test_jal();
    test_wfi();
    test_fetch_err();
    test_counters();
    if (i_dut.i_fetch.i_assert.error_count != 0) begin
      abort_run($sformatf("%0d instruction port assertion failures",
                          i_dut.i_fetch.i_assert.error_count));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verification/fetch_probe_assertions.sv
// ******************************
// Instruction port protocol checks,
// bound into the fetch unit
// ******************************

`timescale 1ns/10ps
`default_nettype none

module fetch_probe_assertions (
  input wire               clk_i,
  input wire               rst_n_i,
  input wire               req_i,
  input fetch_pkg::addr_t  addr_i,
  input wire               gnt_i,
  input wire               rvalid_i,
  input wire               sleep_i
);

  logic        outstanding_q;
  int unsigned error_count = 0;

  // Granted and not yet answered
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (req_i && gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && !gnt_i) |=> (req_i && $stable(addr_i)))
    else begin
      error_count++;
      $error("instr_req or instr_addr changed before grant");
    end

  rvalid_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> outstanding_q)
    else begin
      error_count++;
      $error("rvalid without an outstanding request");
    end

  asleep_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sleep_i |-> !req_i)
    else begin
      error_count++;
      $error("request raised while the core sleeps");
    end

endmodule

bind instr_fetch fetch_probe_assertions i_assert (
  .clk_i    (clk_i         ),
  .rst_n_i  (rst_n_i       ),
  .req_i    (instr_req_o   ),
  .addr_i   (instr_addr_o  ),
  .gnt_i    (instr_gnt_i   ),
  .rvalid_i (instr_rvalid_i),
  .sleep_i  (core_sleep_o  )
);

`default_nettype wire

// File: hw/fetch_probe_top.sv
// ******************************
// Fetch probe subsystem top: fetch unit,
// decoder and register block
// ******************************

`timescale 1ns/10ps
`default_nettype none

module fetch_probe_top (
  input  wire                    clk_i,
  input  wire                    rst_n_i,

  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  wire                    instr_gnt_i,
  input  wire                    instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  input  wire                    instr_err_i,

  input  wire                    irq_i,

  input  wire                    reg_we_i,
  input  fetch_pkg::reg_addr_t   reg_addr_i,
  input  wire [31:0]             reg_wdata_i,
  output logic [31:0]            reg_rdata_o,

  output logic                   instr_valid_o,
  output fetch_pkg::class_t      instr_class_o,
  output fetch_pkg::addr_t       instr_pc_o,
  output logic                   core_sleep_o
);

  import fetch_pkg::*;

  logic   fetch_enable;
  addr_t  boot_addr;
  logic   word_valid;
  logic   jump_taken;
  addr_t  jump_target;
  class_t word_class;

  instr_fetch i_fetch (
    .clk_i          (clk_i         ),
    .rst_n_i        (rst_n_i       ),
    .fetch_enable_i (fetch_enable  ),
    .boot_addr_i    (boot_addr     ),
    .instr_req_o    (instr_req_o   ),
    .instr_addr_o   (instr_addr_o  ),
    .instr_gnt_i    (instr_gnt_i   ),
    .instr_rvalid_i (instr_rvalid_i),
    .irq_i          (irq_i         ),
    .word_valid_o   (word_valid    ),
    .jump_taken_i   (jump_taken    ),
    .jump_target_i  (jump_target   ),
    .class_i        (word_class    ),
    .instr_valid_o  (instr_valid_o ),
    .instr_class_o  (instr_class_o ),
    .instr_pc_o     (instr_pc_o    ),
    .core_sleep_o   (core_sleep_o  )
  );

  // Decodes the word while rvalid is high, addr still holds its pc
  sys_instr_decoder i_decoder (
    .word_valid_i  (word_valid   ),
    .rdata_i       (instr_rdata_i),
    .err_i         (instr_err_i  ),
    .pc_i          (instr_addr_o ),
    .class_o       (word_class   ),
    .jump_taken_o  (jump_taken   ),
    .jump_target_o (jump_target  )
  );

  fetch_cfg_regs i_regs (
    .clk_i          (clk_i        ),
    .rst_n_i        (rst_n_i      ),
    .reg_we_i       (reg_we_i     ),
    .reg_addr_i     (reg_addr_i   ),
    .reg_wdata_i    (reg_wdata_i  ),
    .reg_rdata_o    (reg_rdata_o  ),
    .instr_valid_i  (instr_valid_o),
    .instr_class_i  (instr_class_o),
    .fetch_enable_o (fetch_enable ),
    .boot_addr_o    (boot_addr    )
  );

endmodule

`default_nettype wire

// File: hw/fetch_cfg_regs.sv
// ******************************
// Fetch control registers and
// per-class event counters
// ******************************

`timescale 1ns/10ps
`default_nettype none

module fetch_cfg_regs (
  input  wire                    clk_i,
  input  wire                    rst_n_i,

  input  wire                    reg_we_i,
  input  fetch_pkg::reg_addr_t   reg_addr_i,
  input  wire [31:0]             reg_wdata_i,
  output logic [31:0]            reg_rdata_o,

  input  wire                    instr_valid_i,
  input  fetch_pkg::class_t      instr_class_i,

  output logic                   fetch_enable_o,
  output fetch_pkg::addr_t       boot_addr_o
);

  import fetch_pkg::*;

  logic   enable_q;
  addr_t  boot_q;
  count_t cnt_q [NUM_CLASSES];
  logic [2:0] cnt_sel;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      boot_q   <= BOOT_RESET;
    end else if (reg_we_i) begin
      if (reg_addr_i == REG_CTRL) begin
        enable_q <= reg_wdata_i[0];
      end
      if (reg_addr_i == REG_BOOT) begin
        boot_q <= reg_wdata_i;
      end
    end
  end

  // One counter per class, a write clears it
  for (genvar k = 0; k < NUM_CLASSES; k++) begin : g_cnt
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q[k] <= '0;
      end else if (reg_we_i && (reg_addr_i == REG_COUNT_BASE + reg_addr_t'(k))) begin
        cnt_q[k] <= '0;
      end else if (instr_valid_i && (instr_class_i == class_t'(k))) begin
        // Wraps at full scale
        cnt_q[k] <= cnt_q[k] + count_t'(1);
      end
    end
  end

  assign cnt_sel = 3'(reg_addr_i - REG_COUNT_BASE);

  // Combinational read
  always_comb begin
    reg_rdata_o = '0;
    if (reg_addr_i >= REG_COUNT_BASE) begin
      reg_rdata_o = {16'd0, cnt_q[cnt_sel]};
    end else if (reg_addr_i == REG_CTRL) begin
      reg_rdata_o = {31'd0, enable_q};
    end else if (reg_addr_i == REG_BOOT) begin
      reg_rdata_o = boot_q;
    end
  end

  assign fetch_enable_o = enable_q;
  assign boot_addr_o    = boot_q;

endmodule

`default_nettype wire

// File: hw/sys_instr_decoder.sv
// ******************************
// Classifies fetched words and
// computes JAL targets
// ******************************

`timescale 1ns/10ps
`default_nettype none

module sys_instr_decoder (
  input  wire                word_valid_i,
  input  fetch_pkg::instr_t  rdata_i,
  input  wire                err_i,
  input  fetch_pkg::addr_t   pc_i,
  output fetch_pkg::class_t  class_o,
  output logic               jump_taken_o,
  output fetch_pkg::addr_t   jump_target_o
);

  import fetch_pkg::*;

  logic [6:0]  opcode;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic [4:0]  rs1;
  logic [11:0] funct12;
  logic        sys_plain;
  logic        bad_word;
  addr_t       j_imm;
  class_t      word_class;

  assign opcode  = rdata_i[6:0];
  assign rd      = rdata_i[11:7];
  assign funct3  = rdata_i[14:12];
  assign rs1     = rdata_i[19:15];
  assign funct12 = rdata_i[31:20];

  // SYSTEM with all operand fields zero
  assign sys_plain = (opcode == OPC_SYSTEM) && (funct3 == 3'b000) &&
                     (rs1 == 5'd0) && (rd == 5'd0);

  // Compressed encodings and all-zero/all-one words
  assign bad_word = (rdata_i[1:0] != 2'b11) || (rdata_i == '0) || (rdata_i == '1);

  always_comb begin
    word_class = CLASS_OTHER;
    if (err_i) begin
      word_class = CLASS_FETCH_ERR;
    end else if (bad_word) begin
      word_class = CLASS_ILLEGAL;
    end else if (sys_plain) begin
      case (funct12)
        F12_ECALL:  word_class = CLASS_ECALL;
        F12_EBREAK: word_class = CLASS_EBREAK;
        F12_MRET:   word_class = CLASS_MRET;
        F12_DRET:   word_class = CLASS_DRET;
        F12_WFI:    word_class = CLASS_WFI;
        default:    word_class = CLASS_ILLEGAL;
      endcase
    end
  end

  assign class_o = word_valid_i ? word_class : CLASS_OTHER;

  // J-type immediate, bit 0 always zero
  assign j_imm = {{11{rdata_i[31]}}, rdata_i[31], rdata_i[19:12],
                  rdata_i[20], rdata_i[30:21], 1'b0};

  // A faulting fetch never redirects
  assign jump_taken_o  = word_valid_i && !err_i && (opcode == OPC_JAL);
  assign jump_target_o = pc_i + j_imm;

endmodule

`default_nettype wire

// File: hw/instr_fetch.sv
// ******************************
// Instruction fetch unit: one outstanding
// request, PC update, wfi sleep
// ******************************

`timescale 1ns/10ps
`default_nettype none

module instr_fetch (
  input  wire                clk_i,
  input  wire                rst_n_i,

  input  wire                fetch_enable_i,
  input  fetch_pkg::addr_t   boot_addr_i,

  output logic               instr_req_o,
  output fetch_pkg::addr_t   instr_addr_o,
  input  wire                instr_gnt_i,
  input  wire                instr_rvalid_i,

  input  wire                irq_i,

  output logic               word_valid_o,
  input  wire                jump_taken_i,
  input  fetch_pkg::addr_t   jump_target_i,
  input  fetch_pkg::class_t  class_i,

  output logic               instr_valid_o,
  output fetch_pkg::class_t  instr_class_o,
  output fetch_pkg::addr_t   instr_pc_o,
  output logic               core_sleep_o
);

  import fetch_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_REPORT,
    ST_SLEEP
  } state_e;

  state_e state_q;
  state_e state_d;
  addr_t  pc_q;
  addr_t  rep_pc_q;
  class_t rep_class_q;
  logic   valid_q;

  // Word accepted from the memory this cycle
  assign word_valid_o = (state_q == ST_WAIT) && instr_rvalid_i;

  // Report cycle raises the next request straight away unless disabled
  assign instr_req_o  = (state_q == ST_REQ) ||
                        ((state_q == ST_REPORT) && fetch_enable_i);
  assign instr_addr_o = pc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (fetch_enable_i) begin
          state_d = ST_REQ;
        end
      end
      // Hold req and addr until granted
      ST_REQ: begin
        if (instr_gnt_i) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = (class_i == CLASS_WFI) ? ST_SLEEP : ST_REPORT;
        end
      end
      ST_REPORT: begin
        if (!fetch_enable_i) begin
          state_d = ST_IDLE;
        end else if (instr_gnt_i) begin
          state_d = ST_WAIT;
        end else begin
          state_d = ST_REQ;
        end
      end
      // Wake on interrupt, pc already points past the wfi
      ST_SLEEP: begin
        if (irq_i) begin
          state_d = fetch_enable_i ? ST_REQ : ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= word_valid_o;
    end
  end

  // PC and reported word info
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && fetch_enable_i) begin
      pc_q <= boot_addr_i;
    end else if (word_valid_o) begin
      pc_q        <= jump_taken_i ? jump_target_i : pc_q + addr_t'(4);
      rep_pc_q    <= pc_q;
      rep_class_q <= class_i;
    end
  end

  assign instr_valid_o = valid_q;
  assign instr_class_o = rep_class_q;
  assign instr_pc_o    = rep_pc_q;
  assign core_sleep_o  = (state_q == ST_SLEEP);

endmodule

`default_nettype wire

// File: hw/fetch_pkg.sv
// ******************************
// Fetch probe shared types, class codes,
// register map and opcode constants
// ******************************

`default_nettype none

package fetch_pkg;

  // Datapath widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [2:0]  class_t;
  typedef logic [15:0] count_t;
  typedef logic [3:0]  reg_addr_t;

  // Instruction classes, one event counter each
  localparam class_t CLASS_OTHER     = 3'd0;
  localparam class_t CLASS_ECALL     = 3'd1;
  localparam class_t CLASS_EBREAK    = 3'd2;
  localparam class_t CLASS_MRET      = 3'd3;
  localparam class_t CLASS_DRET      = 3'd4;
  localparam class_t CLASS_WFI       = 3'd5;
  localparam class_t CLASS_ILLEGAL   = 3'd6;
  localparam class_t CLASS_FETCH_ERR = 3'd7;
  localparam int     NUM_CLASSES     = 8;

  // Register port word indices
  localparam reg_addr_t REG_CTRL       = 4'd0;
  localparam reg_addr_t REG_BOOT       = 4'd1;
  localparam reg_addr_t REG_COUNT_BASE = 4'd8;

  // RV32 major opcodes
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct12 of the privileged SYSTEM instructions
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;
  localparam logic [11:0] F12_DRET   = 12'h7b2;
  localparam logic [11:0] F12_WFI    = 12'h105;

  localparam addr_t BOOT_RESET = 32'h0000_0080;

endpackage

`default_nettype wire
